//--- radio_core.f
common/radio_regs_pkg.sv
common/radio_sample_pkg.sv
hw/settings/radio_settings.sv
hw/tx_path/tx_sample_intake.sv
hw/tx_path/tx_sample_fifo.sv
hw/tx_path/tx_dac_frontend.sv
hw/radio_core.sv
sim/tb_radio_core.sv

//--- Bender.yml
package:
  name: radio_core

sources:
  # Packages first, then RTL bottom up
  - files:
      - common/radio_regs_pkg.sv
      - common/radio_sample_pkg.sv
      - hw/settings/radio_settings.sv
      - hw/tx_path/tx_sample_intake.sv
      - hw/tx_path/tx_sample_fifo.sv
      - hw/tx_path/tx_dac_frontend.sv
      - hw/radio_core.sv
  - target: simulation
    files:
      - sim/tb_radio_core.sv

//--- sim/radio_core_input.txt
# cmd a b in hex: W addr data, P sample, D dac strobe, R/K rx_run/clk_status level, I idle cycles
# N/X count base: push or pop and check a burst; E/G/A/B/S/F check leds gpio adc phy dac flags
K 1 0
E 04 0
G 00000000 0
A 0 0
B 1 0
F 0 0
W 03 0000005a
E 44 0
W 06 000000f0
E 0a 0
W 06 0000001e
E 44 0
W 02 00000009
A 9 0
W 04 00000001
B 0 0
W 04 00000000
B 1 0
W b8 11111111
W b9 22222222
W ba 33333333
W bb 44444444
G 11111111 0
P 12345678 0
P 9abcdef0 0
D 0 0
S 12345678 0
D 0 0
S 9abcdef0 0
P 80018001 0
D 0 0
S 80018001 0
E 54 0
G 33333333 0
R 1 0
E 5c 0
G 44444444 0
P 7fff7fff 0
D 0 0
S 7fff7fff 0
G 22222222 0
R 0 0
E 44 0
N 11 a0000001
F 2 0
X 10 a0000001
D 0 0
S 0 0
F 3 0
P 00010001 0
W 90 0
I 1 0
F 0 0
D 0 0
S 0 0
F 1 0

//--- sim/tb_radio_core.sv
// Radio core testbench

`timescale 1ns/100ps
`default_nettype none

module tb_radio_core;

   localparam int RESET_CYCLES    = 10;
   localparam int DAC_TIMEOUT     = 20;
   localparam int WATCHDOG_CYCLES = 5000;

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic [31:0] sample_i;
   logic        sample_stb_i;
   logic        dac_stb_i;
   logic        rx_run_i;
   logic        clk_status_i;
   logic [15:0] dac_a_o;
   logic [15:0] dac_b_o;
   logic [7:0]  leds_o;
   logic [31:0] gpio_o;
   logic [3:0]  adc_ctrl_o;
   logic        phy_reset_n_o;
   logic        overrun_o;
   logic        underrun_o;

   radio_core i_radio_core (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .sample_i      (sample_i),
      .sample_stb_i  (sample_stb_i),
      .dac_stb_i     (dac_stb_i),
      .rx_run_i      (rx_run_i),
      .clk_status_i  (clk_status_i),
      .dac_a_o       (dac_a_o),
      .dac_b_o       (dac_b_o),
      .leds_o        (leds_o),
      .gpio_o        (gpio_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .overrun_o     (overrun_o),
      .underrun_o    (underrun_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever begin
         #2 dsp_clk = ~dsp_clk;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge dsp_clk);
      $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      report_failure();
   end

   task automatic report_failure();
      $display("Testbench failed");
      $fatal(1);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_sample(input radio_sample_pkg::sample_u expected,
                               input radio_sample_pkg::sample_u actual);
      if (actual.raw !== expected.raw) begin
         $display("ERROR: %0t ns dac_a_o/dac_b_o expected %h actual %h",
                  $time, expected.raw, actual.raw);
         report_failure();
      end
   endtask

   task automatic check_leds(input radio_regs_pkg::led_t expected,
                             input radio_regs_pkg::led_t actual);
      if (actual !== expected) begin
         $display("ERROR: %0t ns leds_o expected %h actual %h", $time, expected, actual);
         report_failure();
      end
   endtask

   task automatic check_gpio(input radio_regs_pkg::gpio_word_t expected,
                             input radio_regs_pkg::gpio_word_t actual);
      if (actual !== expected) begin
         $display("ERROR: %0t ns gpio_o expected %h actual %h", $time, expected, actual);
         report_failure();
      end
   endtask

   task automatic check_adc(input radio_regs_pkg::adc_ctrl_t expected,
                            input radio_regs_pkg::adc_ctrl_t actual);
      if (actual !== expected) begin
         $display("ERROR: %0t ns adc_ctrl_o expected %b actual %b", $time, expected, actual);
         report_failure();
      end
   endtask

   // Only overrun and underrun reach the ports
   task automatic check_flags(input radio_sample_pkg::tx_status_t expected,
                              input radio_sample_pkg::tx_status_t actual);
      if (actual.overrun !== expected.overrun || actual.underrun !== expected.underrun) begin
         $display("ERROR: %0t ns overrun_o/underrun_o expected %b%b actual %b%b", $time,
                  expected.overrun, expected.underrun, actual.overrun, actual.underrun);
         report_failure();
      end
   endtask

   task automatic check_bit(input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERROR: %0t ns phy_reset_n_o expected %b actual %b", $time, expected, actual);
         report_failure();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i <= 1'b0;
   endtask

   task automatic push_sample(input logic [31:0] data);
      @(posedge dsp_clk);
      sample_stb_i <= 1'b1;
      sample_i     <= data;
      @(posedge dsp_clk);
      sample_stb_i <= 1'b0;
   endtask

   task automatic pulse_dac();
      @(posedge dsp_clk);
      dac_stb_i <= 1'b1;
      @(posedge dsp_clk);
      dac_stb_i <= 1'b0;
   endtask

   // Burst word k steps both halves so I and Q differ per entry
   function automatic logic [31:0] burst_sample(input logic [31:0] base, input int k);
      return base + k * 32'h0001_0001;
   endfunction

   // Poll the DAC pair until it shows the sample or the timeout runs out
   task automatic wait_dac(input radio_sample_pkg::sample_u expected);
      radio_sample_pkg::sample_u actual;
      int                        cycles;
      cycles = 0;
      @(negedge dsp_clk);
      actual.iq.i = dac_a_o;
      actual.iq.q = dac_b_o;
      while (actual.raw !== expected.raw && cycles < DAC_TIMEOUT) begin
         @(negedge dsp_clk);
         actual.iq.i = dac_a_o;
         actual.iq.q = dac_b_o;
         cycles++;
      end
      if (actual.raw !== expected.raw) begin
         $display("DAC pair did not update within %0d cycles", DAC_TIMEOUT);
      end
      check_sample(expected, actual);
   endtask

   task automatic push_burst(input int count, input logic [31:0] base);
      for (int k = 0; k < count; k++) begin
         push_sample(burst_sample(base, k));
      end
   endtask

   task automatic pop_burst(input int count, input logic [31:0] base);
      radio_sample_pkg::sample_u expected;
      for (int k = 0; k < count; k++) begin
         expected.raw = burst_sample(base, k);
         pulse_dac();
         wait_dac(expected);
      end
   endtask

   task automatic run_command(input logic [7:0] cmd, input logic [31:0] arg_a,
                              input logic [31:0] arg_b);
      radio_sample_pkg::sample_u    exp_sample;
      radio_sample_pkg::tx_status_t exp_flags;
      radio_sample_pkg::tx_status_t act_flags;
      exp_sample.raw = arg_a;
      // Flag word holds overrun in bit 1 and underrun in bit 0
      exp_flags = {arg_a[1:0], 1'b0};
      case (cmd)
         "W": write_setting(arg_a[7:0], arg_b);
         "P": push_sample(arg_a);
         "D": pulse_dac();
         "N": push_burst(arg_a, arg_b);
         "X": pop_burst(arg_a, arg_b);
         "S": wait_dac(exp_sample);
         "I": repeat (arg_a) @(posedge dsp_clk);
         "R": begin
            @(posedge dsp_clk);
            rx_run_i <= arg_a[0];
         end
         "K": begin
            @(posedge dsp_clk);
            clk_status_i <= arg_a[0];
         end
         "E": begin
            @(negedge dsp_clk);
            check_leds(arg_a[7:0], leds_o);
         end
         "G": begin
            @(negedge dsp_clk);
            check_gpio(arg_a, gpio_o);
         end
         "A": begin
            @(negedge dsp_clk);
            check_adc(arg_a[3:0], adc_ctrl_o);
         end
         "B": begin
            @(negedge dsp_clk);
            check_bit(arg_a[0], phy_reset_n_o);
         end
         "F": begin
            @(negedge dsp_clk);
            act_flags = {overrun_o, underrun_o, 1'b0};
            check_flags(exp_flags, act_flags);
         end
         default: begin
            $display("Unknown command '%s' in the stimulus file", cmd);
            report_failure();
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int               fd;
      int               code;
      logic [7:0]       cmd;
      logic [31:0]      arg_a;
      logic [31:0]      arg_b;
      logic [8*256-1:0] rest;
      por_rst      = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      sample_i     = '0;
      sample_stb_i = 1'b0;
      dac_stb_i    = 1'b0;
      rx_run_i     = 1'b0;
      clk_status_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      por_rst <= 1'b0;
      fd = $fopen("sim/radio_core_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file sim/radio_core_input.txt");
         report_failure();
      end else begin
         code = $fscanf(fd, " %c", cmd);
         while (code == 1) begin
            if (cmd == "#") begin
               // Drop the rest of a comment line
               code = $fgets(rest, fd);
            end else begin
               code = $fscanf(fd, " %h %h", arg_a, arg_b);
               if (code != 2) begin
                  $display("Stimulus line for command '%s' is missing its arguments", cmd);
                  report_failure();
               end
               run_command(cmd, arg_a, arg_b);
            end
            code = $fscanf(fd, " %c", cmd);
         end
         $fclose(fd);
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- hw/radio_core.sv
// Radio core sample-rate control slice

`timescale 1ns/100ps
`default_nettype none

module radio_core (
   input  wire         dsp_clk,
   input  wire         por_rst,
   input  wire         set_stb_i,
   input  wire  [7:0]  set_addr_i,
   input  wire  [31:0] set_data_i,
   input  wire  [31:0] sample_i,
   input  wire         sample_stb_i,
   input  wire         dac_stb_i,
   input  wire         rx_run_i,
   input  wire         clk_status_i,
   output logic [15:0] dac_a_o,
   output logic [15:0] dac_b_o,
   output logic [7:0]  leds_o,
   output logic [31:0] gpio_o,
   output logic [3:0]  adc_ctrl_o,
   output logic        phy_reset_n_o,
   output logic        overrun_o,
   output logic        underrun_o
);

   radio_regs_pkg::set_bus_t   set_bus;
   radio_sample_pkg::sample_u  sample_in;
   radio_sample_pkg::sample_u  wr_data;
   radio_sample_pkg::sample_u  head;
   logic                       tx_clear;
   logic                       tx_en;
   logic                       wr_stb;
   logic                       rd_stb;
   logic                       fifo_full;
   logic                       fifo_empty;

   assign set_bus.stb  = set_stb_i;
   assign set_bus.addr = set_addr_i;
   assign set_bus.data = set_data_i;

   assign sample_in.raw = sample_i;

   ////////////////////////////////////////////////////////////
   // Settings and TX path
   ////////////////////////////////////////////////////////////

   radio_settings i_radio_settings (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .set_bus_i     (set_bus),
      .tx_en_i       (tx_en),
      .rx_run_i      (rx_run_i),
      .clk_status_i  (clk_status_i),
      .leds_o        (leds_o),
      .gpio_o        (gpio_o),
      .adc_ctrl_o    (adc_ctrl_o),
      .phy_reset_n_o (phy_reset_n_o),
      .tx_clear_o    (tx_clear)
   );

   tx_sample_intake i_tx_sample_intake (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .sample_i     (sample_in),
      .sample_stb_i (sample_stb_i),
      .clear_i      (tx_clear),
      .full_i       (fifo_full),
      .wr_stb_o     (wr_stb),
      .wr_data_o    (wr_data),
      .overrun_o    (overrun_o)
   );

   tx_sample_fifo i_tx_sample_fifo (
      .dsp_clk   (dsp_clk),
      .por_rst   (por_rst),
      .clear_i   (tx_clear),
      .wr_stb_i  (wr_stb),
      .wr_data_i (wr_data),
      .rd_stb_i  (rd_stb),
      .head_o    (head),
      .full_o    (fifo_full),
      .empty_o   (fifo_empty)
   );

   tx_dac_frontend i_tx_dac_frontend (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .dac_stb_i  (dac_stb_i),
      .clear_i    (tx_clear),
      .empty_i    (fifo_empty),
      .head_i     (head),
      .rd_stb_o   (rd_stb),
      .dac_a_o    (dac_a_o),
      .dac_b_o    (dac_b_o),
      .tx_en_o    (tx_en),
      .underrun_o (underrun_o)
   );

endmodule

`default_nettype wire

//--- hw/tx_path/tx_dac_frontend.sv
// DAC frontend with magic word TX enable

`timescale 1ns/100ps
`default_nettype none

module tx_dac_frontend (
   input  wire                                    dsp_clk,
   input  wire                                    por_rst,
   input  wire                                    dac_stb_i,
   input  wire                                    clear_i,
   input  wire                                    empty_i,
   input  radio_sample_pkg::sample_u              head_i,
   output logic                                   rd_stb_o,
   output logic [radio_sample_pkg::IQ_W-1:0]      dac_a_o,
   output logic [radio_sample_pkg::IQ_W-1:0]      dac_b_o,
   output logic                                   tx_en_o,
   output logic                                   underrun_o
);

   logic pop;
   logic starved;
   logic is_magic_tx;
   logic is_magic_rx;

   // One pop per DAC strobe while samples wait
   assign pop      = dac_stb_i && !empty_i;
   assign starved  = dac_stb_i && empty_i;
   assign rd_stb_o = pop;

   assign is_magic_tx = (head_i.raw == radio_sample_pkg::MAGIC_TX);
   assign is_magic_rx = (head_i.raw == radio_sample_pkg::MAGIC_RX);

   ////////////////////////////////////////////////////////////
   // DAC registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end else if (pop) begin
         // Magic words still go out
         dac_a_o <= head_i.iq.i;
         dac_b_o <= head_i.iq.q;
      end else if (starved) begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Status
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         underrun_o <= 1'b0;
         tx_en_o    <= 1'b0;
      end else begin
         if (starved) begin
            underrun_o <= 1'b1;
         end
         // TX on with 0x8001 pairs and off with 0x7fff pairs
         if (pop && is_magic_tx) begin
            tx_en_o <= 1'b1;
         end else if (pop && is_magic_rx) begin
            tx_en_o <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/tx_path/tx_sample_fifo.sv
// Circular TX sample buffer

`timescale 1ns/100ps
`default_nettype none

module tx_sample_fifo (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   input  wire                        clear_i,
   input  wire                        wr_stb_i,
   input  radio_sample_pkg::sample_u  wr_data_i,
   input  wire                        rd_stb_i,
   output radio_sample_pkg::sample_u  head_o,
   output logic                       full_o,
   output logic                       empty_o
);

   radio_sample_pkg::sample_u                  mem [radio_sample_pkg::FIFO_DEPTH];
   logic [radio_sample_pkg::FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [radio_sample_pkg::FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [radio_sample_pkg::FIFO_DEPTH_LOG2:0]   count;
   logic                                       do_wr;
   logic                                       do_rd;

   assign full_o  = (count == radio_sample_pkg::FIFO_DEPTH);
   assign empty_o = (count == '0);

   // Guard against writing full or reading empty
   assign do_wr = wr_stb_i && !full_o;
   assign do_rd = rd_stb_i && !empty_o;

   assign head_o = mem[rd_ptr];

   always_ff @(posedge dsp_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Push and pop together keep the count
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/tx_path/tx_sample_intake.sv
// TX sample intake with overrun flag

`timescale 1ns/100ps
`default_nettype none

module tx_sample_intake (
   input  wire                        dsp_clk,
   input  wire                        por_rst,
   input  radio_sample_pkg::sample_u  sample_i,
   input  wire                        sample_stb_i,
   input  wire                        clear_i,
   input  wire                        full_i,
   output logic                       wr_stb_o,
   output radio_sample_pkg::sample_u  wr_data_o,
   output logic                       overrun_o
);

   logic dropped;

   // Strobe against a full buffer loses the sample
   assign dropped = sample_stb_i && full_i;

   // Forward while there is room, clear wins
   assign wr_stb_o  = sample_stb_i && !full_i && !clear_i;
   assign wr_data_o = sample_i;

   // Sticky until the next TX clear
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         overrun_o <= 1'b0;
      end else if (clear_i) begin
         overrun_o <= 1'b0;
      end else if (dropped) begin
         overrun_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/settings/radio_settings.sv
// Radio control registers
// LED source mux and ATR GPIO

`timescale 1ns/100ps
`default_nettype none

module radio_settings (
   input  wire                             dsp_clk,
   input  wire                             por_rst,
   input  radio_regs_pkg::set_bus_t        set_bus_i,
   input  wire                             tx_en_i,
   input  wire                             rx_run_i,
   input  wire                             clk_status_i,
   output radio_regs_pkg::led_t            leds_o,
   output radio_regs_pkg::gpio_word_t      gpio_o,
   output radio_regs_pkg::adc_ctrl_t       adc_ctrl_o,
   output logic                            phy_reset_n_o,
   output logic                            tx_clear_o
);

   radio_regs_pkg::adc_ctrl_t  adc_ctrl;
   radio_regs_pkg::led_t       led_sw;
   radio_regs_pkg::led_t       led_src;
   radio_regs_pkg::led_t       led_hw;
   logic                       phy_reset;
   radio_regs_pkg::gpio_word_t atr_words [4];
   logic [1:0]                 atr_sel;

   ////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         adc_ctrl     <= '0;
         led_sw       <= '0;
         led_src      <= radio_regs_pkg::LED_SRC_RESET;
         phy_reset    <= 1'b0;
         atr_words[0] <= '0;
         atr_words[1] <= '0;
         atr_words[2] <= '0;
         atr_words[3] <= '0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            radio_regs_pkg::SR_MISC + 8'd2: begin
               adc_ctrl <= radio_regs_pkg::adc_ctrl_t'(
                  set_bus_i.data[radio_regs_pkg::ADC_W-1:0]);
            end
            radio_regs_pkg::SR_MISC + 8'd3: begin
               led_sw <= set_bus_i.data[radio_regs_pkg::LED_W-1:0];
            end
            radio_regs_pkg::SR_MISC + 8'd4: begin
               phy_reset <= set_bus_i.data[0];
            end
            radio_regs_pkg::SR_MISC + 8'd6: begin
               led_src <= set_bus_i.data[radio_regs_pkg::LED_W-1:0];
            end
            radio_regs_pkg::SR_GPIO + 8'd0: begin
               atr_words[0] <= set_bus_i.data;
            end
            radio_regs_pkg::SR_GPIO + 8'd1: begin
               atr_words[1] <= set_bus_i.data;
            end
            radio_regs_pkg::SR_GPIO + 8'd2: begin
               atr_words[2] <= set_bus_i.data;
            end
            radio_regs_pkg::SR_GPIO + 8'd3: begin
               atr_words[3] <= set_bus_i.data;
            end
            default: begin
            end
         endcase
      end
   end

   // Any write to the TX control address pulses the clear
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         tx_clear_o <= 1'b0;
      end else begin
         tx_clear_o <= set_bus_i.stb && (set_bus_i.addr == radio_regs_pkg::SR_TX_CTRL);
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////

   // Hardware status bits
   assign led_hw = {3'b000, tx_en_i, rx_run_i, clk_status_i, 2'b00};

   // Mask 1 takes the hardware bit and mask 0 the software bit
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // 00 idle, 01 rx only, 10 tx only, 11 full duplex
   assign atr_sel = {tx_en_i, rx_run_i};
   assign gpio_o  = atr_words[atr_sel];

   assign adc_ctrl_o    = adc_ctrl;
   assign phy_reset_n_o = ~phy_reset;

endmodule

`default_nettype wire

//--- common/radio_sample_pkg.sv
// TX sample types and buffer sizing

`default_nettype none

package radio_sample_pkg;

   localparam int IQ_W     = 16;
   localparam int SAMPLE_W = 2 * IQ_W;

   // I in the upper half, Q in the lower
   typedef struct packed {
      logic [IQ_W-1:0] i;
      logic [IQ_W-1:0] q;
   } iq_t;

   // Raw view for magic word compare, iq view for the DAC split
   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      iq_t                 iq;
   } sample_u;

   // Magic words that switch transmit off and on
   localparam logic [SAMPLE_W-1:0] MAGIC_RX = 32'h7fff_7fff;
   localparam logic [SAMPLE_W-1:0] MAGIC_TX = 32'h8001_8001;

   // Buffer holds 16 samples
   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;

   typedef struct packed {
      logic overrun;
      logic underrun;
      logic tx_en;
   } tx_status_t;

endpackage

`default_nettype wire

//--- common/radio_regs_pkg.sv
// Radio core settings register map
// Addresses, widths and reset values

`default_nettype none

package radio_regs_pkg;

   ////////////////////////////////////////////////////////////
   // Bus and register widths
   ////////////////////////////////////////////////////////////

   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;
   localparam int LED_W  = 8;
   localparam int GPIO_W = 32;
   localparam int ADC_W  = 4;

   ////////////////////////////////////////////////////////////
   // Settings addresses
   ////////////////////////////////////////////////////////////

   // Misc block with ADC ctrl at +2, LED sw at +3, PHY reset at +4 and LED src at +6
   localparam logic [ADDR_W-1:0] SR_MISC    = 8'd0;
   // Any write here pulses the TX clear
   localparam logic [ADDR_W-1:0] SR_TX_CTRL = 8'd144;
   // ATR words idle, rx-only, tx-only, full-duplex at +0 to +3
   localparam logic [ADDR_W-1:0] SR_GPIO    = 8'd184;

   // Reset LED source mask where 1 selects the hardware bit
   localparam logic [LED_W-1:0] LED_SRC_RESET = 8'h1E;

   ////////////////////////////////////////////////////////////
   // Settings types
   ////////////////////////////////////////////////////////////

   // One settings write
   typedef struct packed {
      logic              stb;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } set_bus_t;

   typedef logic [LED_W-1:0] led_t;

   // Upper half io_tx, lower half io_rx
   typedef logic [GPIO_W-1:0] gpio_word_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

endpackage

`default_nettype wire
